// File: sd_controller_top.f
hdl/sd_pkg.sv
hdl/spi_byte_if.sv
hdl/sd_clock_gen.sv
hdl/sd_spi_engine.sv
hdl/sd_controller.sv
hdl/sd_test_driver.sv
hdl/sd_controller_top.sv
tb/sd_card_model.sv
tb/sd_controller_checker.sv
tb/sd_controller_tb.sv

// File: Makefile
TOP = sd_controller_tb

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sd_controller_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean

// File: tb/sd_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_controller_tb;
  import sd_pkg::*;

  localparam int init_cycles  = 300_000;  // About 100 slow bytes of 2150 cycles.
  localparam int block_cycles = 60_000;   // 527 fast bytes of about 75 cycles.
  localparam int cycle_limit  = init_cycles + 4 * block_cycles;
  localparam int good_blocks  = 3;        // The card refuses block 3.

  logic        clock_100M;
  logic        reset;
  logic        miso;
  logic [1:0]  sw;
  logic        sd_reset;
  logic        cs;
  logic        sck;
  logic        mosi;
  logic [15:0] led;
  logic        silent_block3;
  logic [31:0] last_block;
  int          tb_errors = 0;
  int          cycle_count = 0;
  int          cs_falls = 0;

  initial clock_100M = 1'b0;
  always #5 clock_100M = ~clock_100M;

  always @(negedge cs) cs_falls++;

  sd_controller_top uut (
    .clock_100M (clock_100M),
    .reset      (reset),
    .miso       (miso),
    .sw         (sw),
    .sd_reset   (sd_reset),
    .cs         (cs),
    .sck        (sck),
    .mosi       (mosi),
    .led        (led)
  );

  sd_card_model card (
    .cs            (cs),
    .sck           (sck),
    .mosi          (mosi),
    .miso          (miso),
    .silent_block3 (silent_block3),
    .last_block    (last_block)
  );

  function automatic logic [31:0] expected_word(input int block);
    logic [31:0] word;
    int          i;
    word = '0;
    for (i = 0; i < 4; i++) begin
      word = {word[23:0], 8'((block * 7 + i) % 256)};  // Byte 0 ends on top.
    end
    return word;
  endfunction

  task automatic close_run();
    int failures;
    failures = tb_errors + uut.checks.fail_count;
    $display("Assertion failures: %0d, testbench errors: %0d",
             uut.checks.fail_count, tb_errors);
    if (failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Shows the state and count, then waits until led holds the wanted pair.
  task automatic wait_for_state(input logic [3:0] state, input logic [11:0] count);
    @(posedge clock_100M);
    #1 sw = 2'b00;
    @(negedge clock_100M);
    while (led != {state, count}) begin
      @(negedge clock_100M);
    end
  endtask

  task automatic check_led(input logic [1:0] sw_value, input logic [15:0] expected);
    @(posedge clock_100M);
    #1 sw = sw_value;
    @(negedge clock_100M);
    assert (led == expected) else begin
      $display("MISMATCH led (sw %b): expected %h, got %h", sw_value, expected, led);
      tb_errors++;
    end
  endtask

  // A random sw setting while the next block is being read.
  task automatic browse_display(input logic [31:0] word, input logic [11:0] count);
    int          hold;
    logic [1:0]  setting;
    logic [15:0] expected;
    hold    = 1 + $urandom % 400;
    setting = 2'($urandom);
    if (!setting[0]) begin
      expected = {drv_read, count};
    end else if (setting[1]) begin
      expected = word[31:16];
    end else begin
      expected = word[15:0];
    end
    check_led(setting, expected);
    repeat (hold) @(posedge clock_100M);
  endtask

  initial begin
    logic [31:0] word;
    int          mark;
    int          block;
    void'($urandom(32'h91c112f9));
    reset         = 1'b1;
    sw            = 2'b00;
    silent_block3 = 1'b1;
    repeat (16) @(posedge clock_100M);
    #1 reset = 1'b0;

    wait_for_state(drv_read, 12'd0);
    mark = cs_falls;
    for (block = 0; block < good_blocks; block++) begin
      wait_for_state(drv_valid, 12'(block + 1));
      assert (cs_falls == mark + 1 && cs) else begin
        $display("cs fell %0d times for block %0d, once expected", cs_falls - mark, block);
        tb_errors++;
      end
      mark = cs_falls;
      assert (last_block == 32'(block)) else begin
        $display("MISMATCH last_block: expected %h, got %h", 32'(block), last_block);
        tb_errors++;
      end
      word = expected_word(block);
      if ($urandom % 2 == 0) begin
        check_led(2'b01, word[15:0]);
        check_led(2'b11, word[31:16]);
      end else begin
        check_led(2'b11, word[31:16]);
        check_led(2'b01, word[15:0]);
      end
      browse_display(word, 12'(block + 1));
    end

    // Block 3 gets no answer, so the driver must stop.
    wait_for_state(drv_error, 12'd3);
    assert (cs_falls == mark + 1) else begin
      $display("cs fell %0d times for the refused block, once expected", cs_falls - mark);
      tb_errors++;
    end
    mark = cs_falls;
    repeat (2000) @(negedge clock_100M);
    assert (cs_falls == mark && cs) else begin
      $display("cs still active after the driver stopped on an error");
      tb_errors++;
    end
    close_run();
  end

  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clock_100M);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with led at %h, the run made no progress",
             cycle_count, led);
    tb_errors++;
    close_run();
  end

endmodule

`default_nettype wire

// File: tb/sd_controller_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sd_controller_checker (
  input logic        clock_100M,
  input logic        reset,
  input logic        sd_reset,
  input logic        cs,
  input logic        sck,
  input logic        mosi,
  input logic [1:0]  sw,
  input logic [15:0] led
);
  import sd_pkg::*;

  int         fail_count = 0;
  int         gap;         // Cycles since the last sck edge.
  int         wake_rises;  // sck rises seen with cs high.
  logic [3:0] edges;       // sck edges so far in the current byte.
  logic [7:0] mosi_byte;
  logic       sck_d;
  logic       fast_seen;
  logic       toggle;

  assign toggle = (sck != sck_d);

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      gap        <= 0;
      wake_rises <= 0;
      edges      <= '0;
      mosi_byte  <= 8'hFF;
      sck_d      <= 1'b0;
      fast_seen  <= 1'b0;
    end else begin
      sck_d <= sck;
      if (toggle) begin
        gap   <= 1;
        edges <= edges + 1'b1;
        if (sck) begin
          mosi_byte <= {mosi_byte[6:0], mosi};
          if (cs) wake_rises <= wake_rises + 1;
        end
        if (edges != 0 && gap == fast_half) fast_seen <= 1'b1;
      end else begin
        gap <= gap + 1;
      end
    end
  end

  a_sd_reset: assert property (@(posedge clock_100M) sd_reset == reset)
    else begin $error("sd_reset does not follow reset"); fail_count++; end

  a_reset_idle: assert property (@(posedge clock_100M) reset |=> cs && !sck && mosi)
    else begin $error("SPI lines not idle around reset"); fail_count++; end

  a_reset_led: assert property (@(posedge clock_100M)
    reset |=> sw[0] || led[15:12] == drv_reset)
    else begin $error("led does not show the reset state"); fail_count++; end

  // Half periods inside a byte are slow until the first fast one, then always fast.
  a_half_period: assert property (@(posedge clock_100M) disable iff (reset)
    toggle && edges != 0 |-> gap == fast_half || (!fast_seen && gap == slow_half))
    else begin $error("sck half period of %0d cycles", gap); fail_count++; end

  a_wake_clocks: assert property (@(posedge clock_100M) disable iff (reset)
    $fell(cs) |-> wake_rises >= 74)
    else begin $error("only %0d sck rises before the first command", wake_rises); fail_count++; end

  a_slow_op_cond: assert property (@(posedge clock_100M) disable iff (reset)
    toggle && edges == 4'd15 && !cs && mosi_byte == {2'b01, acmd_op_cond} |-> !fast_seen)
    else begin $error("ACMD41 sent at the fast rate"); fail_count++; end

  a_fast_read: assert property (@(posedge clock_100M) disable iff (reset)
    toggle && edges == 4'd15 && !cs && mosi_byte == {2'b01, cmd_read_block} |-> fast_seen)
    else begin $error("CMD17 sent at the slow rate"); fail_count++; end

endmodule

bind sd_controller_top sd_controller_checker checks (
  .clock_100M (clock_100M),
  .reset      (reset),
  .sd_reset   (sd_reset),
  .cs         (cs),
  .sck        (sck),
  .mosi       (mosi),
  .sw         (sw),
  .led        (led)
);

`default_nettype wire

// File: tb/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
  input  logic        cs,
  input  logic        sck,
  input  logic        mosi,
  output logic        miso,
  input  logic        silent_block3,
  output logic [31:0] last_block
);
  import sd_pkg::*;

  logic [7:0]  rx_shift;
  logic [2:0]  rx_bits;        // Wraps to zero after each byte.
  logic [7:0]  tx_shift;
  logic [47:0] frame;
  int          frame_len;
  int          op_cond_count;  // ACMD41 answers still showing idle.
  logic [7:0]  reply_q[$];

  initial begin
    rx_shift      = 8'hFF;
    rx_bits       = 3'd0;
    tx_shift      = 8'hFF;
    frame         = '0;
    frame_len     = 0;
    op_cond_count = 0;
    last_block    = '1;  // Nothing served yet.
  end

  assign miso = cs ? 1'b1 : tx_shift[7];

  task automatic push_r1(input logic [7:0] r1);
    reply_q.push_back(8'hFF);  // One byte of response delay.
    reply_q.push_back(r1);
  endtask

  task automatic answer(input logic [5:0] index, input logic [31:0] arg);
    int i;
    case (index)
      cmd_go_idle, cmd_app: push_r1(r1_idle);
      acmd_op_cond: begin
        if (op_cond_count < 3) begin
          op_cond_count++;
          push_r1(r1_idle);
        end else begin
          push_r1(r1_ready);
        end
      end
      cmd_read_block: begin
        if (!(silent_block3 && arg == 32'd3)) begin
          last_block = arg;
          push_r1(r1_ready);
          reply_q.push_back(8'hFF);  // Access time before the token.
          reply_q.push_back(8'hFF);
          reply_q.push_back(token_start);
          for (i = 0; i < block_bytes; i++) begin
            reply_q.push_back(8'((arg * 7 + i) % 256));
          end
          reply_q.push_back(8'hC3);  // CRC, never checked.
          reply_q.push_back(8'h3C);
        end
      end
      default: push_r1(8'h04);  // Illegal command.
    endcase
  endtask

  task automatic take_byte(input logic [7:0] data);
    if (frame_len != 0 || data[7:6] == 2'b01) begin
      frame = {frame[39:0], data};
      frame_len++;
      if (frame_len == 6) begin
        frame_len = 0;
        answer(frame[45:40], frame[39:8]);
      end
    end
  endtask

  // Mode 0, mosi is sampled on the rising edge.
  always @(posedge sck) begin
    rx_shift = {rx_shift[6:0], mosi};
    rx_bits  = rx_bits + 3'd1;
    if (rx_bits == 3'd0 && !cs) begin
      take_byte(rx_shift);
    end
  end

  always @(negedge sck) begin
    if (rx_bits == 3'd0) begin
      if (reply_q.size() > 0) begin
        tx_shift = reply_q.pop_front();  // Next byte, MSB ready before the rise.
      end else begin
        tx_shift = 8'hFF;
      end
    end else begin
      tx_shift = {tx_shift[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

// File: hdl/sd_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_controller_top (
  input  logic        clock_100M,
  input  logic        reset,
  input  logic        miso,
  input  logic [1:0]  sw,
  output logic        sd_reset,
  output logic        cs,
  output logic        sck,
  output logic        mosi,
  output logic [15:0] led
);

  logic        slow_tick;
  logic        fast_tick;
  logic        rd_req;
  logic        rd_ack;
  logic [31:0] block_addr;
  logic [31:0] read_word;
  logic        read_error;
  logic        ready;
  logic        init_error;

  spi_byte_if byte_bus ();

  sd_clock_gen clock_gen (
    .clock_100M (clock_100M),
    .reset      (reset),
    .slow_tick  (slow_tick),
    .fast_tick  (fast_tick)
  );

  sd_spi_engine engine (
    .clock_100M (clock_100M),
    .reset      (reset),
    .slow_tick  (slow_tick),
    .fast_tick  (fast_tick),
    .bus        (byte_bus.engine),
    .sck        (sck),
    .mosi       (mosi),
    .miso       (miso)
  );

  sd_controller controller (
    .clock_100M (clock_100M),
    .reset      (reset),
    .rd_req     (rd_req),
    .block_addr (block_addr),
    .rd_ack     (rd_ack),
    .read_word  (read_word),
    .read_error (read_error),
    .ready      (ready),
    .init_error (init_error),
    .cs         (cs),
    .bus        (byte_bus.host)
  );

  sd_test_driver tester (
    .clock_100M (clock_100M),
    .reset      (reset),
    .ready      (ready),
    .init_error (init_error),
    .rd_ack     (rd_ack),
    .read_word  (read_word),
    .read_error (read_error),
    .rd_req     (rd_req),
    .block_addr (block_addr),
    .sw         (sw),
    .led        (led)
  );

  assign sd_reset = reset;  // Card power control follows system reset.

endmodule

`default_nettype wire

// File: hdl/sd_test_driver.sv
`timescale 1ns/1ps
`default_nettype none

module sd_test_driver (
  input  logic        clock_100M,
  input  logic        reset,
  input  logic        ready,
  input  logic        init_error,
  input  logic        rd_ack,
  input  logic [31:0] read_word,
  input  logic        read_error,
  output logic        rd_req,
  output logic [31:0] block_addr,
  input  logic [1:0]  sw,
  output logic [15:0] led
);
  import sd_pkg::*;

  drv_state_t  state;
  logic [11:0] count;  // Blocks read so far.
  logic [31:0] word;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state      <= drv_reset;
      rd_req     <= 1'b0;
      block_addr <= '0;
      count      <= '0;
      word       <= '0;
    end else begin
      case (state)
        drv_reset: state <= drv_init;
        drv_init: begin
          if (init_error) begin
            state <= drv_error;
          end else if (ready) begin
            state <= drv_read;
          end
        end
        drv_read: begin
          if (!rd_req && !rd_ack) begin
            rd_req <= 1'b1;
          end else if (rd_req && rd_ack) begin
            rd_req <= 1'b0;
            if (read_error) begin
              state <= drv_error;
            end else begin
              word       <= read_word;
              count      <= count + 1'b1;
              block_addr <= block_addr + 1'b1;
              state      <= drv_valid;
            end
          end
        end
        drv_valid: if (!rd_ack) state <= drv_read;  // Handshake closed.
        default: state <= drv_error;
      endcase
    end
  end

  always_comb begin
    if (!sw[0]) begin
      led = {state, count};
    end else if (sw[1]) begin
      led = word[31:16];
    end else begin
      led = word[15:0];
    end
  end

endmodule

`default_nettype wire

// File: hdl/sd_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sd_controller (
  input  logic        clock_100M,
  input  logic        reset,
  input  logic        rd_req,
  input  logic [31:0] block_addr,
  output logic        rd_ack,
  output logic [31:0] read_word,
  output logic        read_error,
  output logic        ready,
  output logic        init_error,
  output logic        cs,
  spi_byte_if.host    bus
);
  import sd_pkg::*;

  typedef enum logic [3:0] {
    st_wake, st_select, st_cmd, st_resp, st_token,
    st_data, st_deselect, st_idle, st_ack, st_halt
  } ctrl_state_t;

  ctrl_state_t state;
  ctrl_state_t resume;      // Where to go after the deselect byte.
  logic [5:0]  cmd;
  logic [47:0] frame;       // Command frame, sent from the top byte.
  logic [9:0]  cnt;
  logic [7:0]  tries;       // Failed ACMD41 attempts.
  logic        xfer_busy;
  logic        byte_done;
  logic [7:0]  rx_data;
  logic        byte_needed;
  logic [7:0]  tx_next;
  logic        r1_ok;

  function automatic logic [47:0] frame_of(input logic [5:0] index, input logic [31:0] arg);
    logic [7:0] crc;
    crc = (index == cmd_go_idle) ? 8'h95 : 8'h01;  // Only CMD0 needs a real CRC.
    return {2'b01, index, arg, crc};
  endfunction

  assign cs          = !(state inside {st_select, st_cmd, st_resp, st_token, st_data});
  assign byte_needed = !(state inside {st_idle, st_ack, st_halt});
  assign tx_next     = (state == st_cmd) ? frame[47:40] : 8'hFF;

  always_comb begin
    case (cmd)
      cmd_go_idle: r1_ok = (rx_data == r1_idle);
      cmd_app:     r1_ok = (rx_data == r1_idle) || (rx_data == r1_ready);
      default:     r1_ok = (rx_data == r1_ready);
    endcase
  end

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state      <= st_wake;
      resume     <= st_idle;
      cmd        <= cmd_go_idle;
      cnt        <= '0;
      tries      <= '0;
      xfer_busy  <= 1'b0;
      byte_done  <= 1'b0;
      bus.req    <= 1'b0;
      bus.slow   <= 1'b1;
      rd_ack     <= 1'b0;
      read_error <= 1'b0;
      ready      <= 1'b0;
      init_error <= 1'b0;
    end else begin
      // Byte handshake with the SPI engine.
      byte_done <= 1'b0;
      if (bus.req && bus.ack) begin
        bus.req <= 1'b0;
        rx_data <= bus.rx_byte;
      end else if (xfer_busy && !bus.req && !bus.ack) begin
        xfer_busy <= 1'b0;
        byte_done <= 1'b1;
      end else if (byte_needed && !xfer_busy && !byte_done) begin
        bus.tx_byte <= tx_next;
        bus.req     <= 1'b1;
        xfer_busy   <= 1'b1;
      end

      case (state)
        st_wake: if (byte_done) begin
          if (cnt == init_bytes - 1) begin
            cmd   <= cmd_go_idle;
            frame <= frame_of(cmd_go_idle, 32'h0);
            cnt   <= '0;
            state <= st_select;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_select: if (byte_done) begin
          cnt   <= '0;
          state <= st_cmd;
        end
        st_cmd: if (byte_done) begin
          frame <= {frame[39:0], 8'hFF};
          if (cnt == 10'd5) begin
            cnt   <= '0;
            state <= st_resp;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_resp: if (byte_done) begin
          if (rx_data != 8'hFF || cnt == response_tries - 1) begin
            cnt   <= '0;
            state <= st_deselect;
            if (r1_ok && cmd == cmd_go_idle) begin
              cmd    <= cmd_app;
              frame  <= frame_of(cmd_app, 32'h0);
              resume <= st_select;
            end else if (r1_ok && cmd == cmd_app) begin
              cmd    <= acmd_op_cond;
              frame  <= frame_of(acmd_op_cond, 32'h4000_0000);  // HCS set.
              resume <= st_select;
            end else if (r1_ok && cmd == acmd_op_cond) begin
              ready    <= 1'b1;
              bus.slow <= 1'b0;  // Init done, switch to the fast rate.
              resume   <= st_idle;
            end else if (r1_ok) begin
              state <= st_token;  // CMD17 accepted, keep cs low.
            end else if (cmd == acmd_op_cond && rx_data == r1_idle &&
                         tries != op_cond_tries - 1) begin
              tries  <= tries + 1'b1;
              cmd    <= cmd_app;
              frame  <= frame_of(cmd_app, 32'h0);
              resume <= st_select;
            end else if (cmd == cmd_read_block) begin
              read_error <= 1'b1;
              resume     <= st_ack;
            end else begin
              init_error <= 1'b1;
              resume     <= st_halt;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_token: if (byte_done) begin
          if (rx_data == token_start) begin
            cnt   <= '0;
            state <= st_data;
          end else if (rx_data != 8'hFF || cnt == token_tries - 1) begin
            read_error <= 1'b1;  // Error token or no token at all.
            resume     <= st_ack;
            state      <= st_deselect;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_data: if (byte_done) begin
          if (cnt < 10'd4) begin
            read_word <= {read_word[23:0], rx_data};  // First byte ends on top.
          end
          if (cnt == block_bytes + 1) begin
            resume <= st_ack;  // Both CRC bytes dropped.
            state  <= st_deselect;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_deselect: if (byte_done) begin
          cnt   <= '0;
          state <= resume;
        end
        st_idle: begin
          if (rd_req && !rd_ack) begin
            cmd        <= cmd_read_block;
            frame      <= frame_of(cmd_read_block, block_addr);
            read_error <= 1'b0;
            state      <= st_select;
          end
        end
        st_ack: begin
          if (!rd_req) begin
            rd_ack <= 1'b0;
            state  <= st_idle;
          end else begin
            rd_ack <= 1'b1;
          end
        end
        default: ;  // st_halt waits for reset.
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/sd_spi_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sd_spi_engine (
  input  logic       clock_100M,
  input  logic       reset,
  input  logic       slow_tick,
  input  logic       fast_tick,
  spi_byte_if.engine bus,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);

  typedef enum logic [1:0] {
    eng_idle,
    eng_sync,
    eng_shift,
    eng_done
  } eng_state_t;

  eng_state_t state;
  logic       tick;
  logic [3:0] edge_cnt;   // Counts the 16 sck edges of a byte.
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;

  assign tick        = bus.slow ? slow_tick : fast_tick;
  assign mosi        = tx_shift[7];  // Ones shift in, so mosi idles high.
  assign bus.rx_byte = rx_shift;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state    <= eng_idle;
      sck      <= 1'b0;
      edge_cnt <= '0;
      tx_shift <= 8'hFF;
      bus.ack  <= 1'b0;
    end else begin
      case (state)
        eng_idle: begin
          if (bus.req) begin
            tx_shift <= bus.tx_byte;  // MSB is on mosi before the first rise.
            edge_cnt <= '0;
            state    <= eng_sync;
          end
        end
        eng_sync: begin
          if (tick) begin
            state <= eng_shift;  // Align to the tick grid.
          end
        end
        eng_shift: begin
          if (tick) begin
            sck      <= ~sck;
            edge_cnt <= edge_cnt + 1'b1;
            if (!sck) begin
              rx_shift <= {rx_shift[6:0], miso};  // Sample on the rising edge.
            end else begin
              tx_shift <= {tx_shift[6:0], 1'b1};  // Next bit on the falling edge.
            end
            if (edge_cnt == 4'd15) begin
              bus.ack <= 1'b1;
              state   <= eng_done;
            end
          end
        end
        default: begin
          if (!bus.req) begin
            bus.ack <= 1'b0;
            state   <= eng_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/sd_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sd_clock_gen (
  input  logic clock_100M,
  input  logic reset,
  output logic slow_tick,
  output logic fast_tick
);
  import sd_pkg::*;

  logic [$clog2(slow_half)-1:0] slow_cnt;
  logic [$clog2(fast_half)-1:0] fast_cnt;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      slow_cnt  <= '0;
      slow_tick <= 1'b0;
    end else if (slow_cnt == slow_half - 1) begin
      slow_cnt  <= '0;
      slow_tick <= 1'b1;  // One pulse per slow half period.
    end else begin
      slow_cnt  <= slow_cnt + 1'b1;
      slow_tick <= 1'b0;
    end
  end

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      fast_cnt  <= '0;
      fast_tick <= 1'b0;
    end else if (fast_cnt == fast_half - 1) begin
      fast_cnt  <= '0;
      fast_tick <= 1'b1;  // One pulse per fast half period.
    end else begin
      fast_cnt  <= fast_cnt + 1'b1;
      fast_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;
  logic       req;      // Host asks for one byte exchange.
  logic       ack;      // Engine finished, rx_byte valid.
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;
  logic       slow;     // Use the slow sck rate.

  modport host (
    output req, tx_byte, slow,
    input  ack, rx_byte
  );

  modport engine (
    input  req, tx_byte, slow,
    output ack, rx_byte
  );
endinterface

`default_nettype wire

// File: hdl/sd_pkg.sv
`default_nettype none

package sd_pkg;

  // Command indices, sent after the 01 start bits.
  localparam logic [5:0] cmd_go_idle    = 6'd0;
  localparam logic [5:0] cmd_app        = 6'd55;
  localparam logic [5:0] acmd_op_cond   = 6'd41;
  localparam logic [5:0] cmd_read_block = 6'd17;

  localparam logic [7:0] token_start = 8'hFE;  // Single block data token.
  localparam logic [7:0] r1_idle     = 8'h01;  // Card in idle state.
  localparam logic [7:0] r1_ready    = 8'h00;  // No error, card ready.

  localparam int block_bytes    = 512;
  localparam int init_bytes     = 10;   // 80 clocks with cs high.
  localparam int response_tries = 8;
  localparam int token_tries    = 255;
  localparam int op_cond_tries  = 255;

  // Half periods of sck in clock_100M cycles.
  localparam int slow_half = 125;  // About 400 kHz.
  localparam int fast_half = 4;    // 12.5 MHz.

  typedef enum logic [3:0] {
    drv_reset = 4'd0,
    drv_init  = 4'd1,
    drv_read  = 4'd2,
    drv_valid = 4'd3,
    drv_error = 4'd15
  } drv_state_t;

endpackage

`default_nettype wire
